//--- common/eth_defs.svh
`ifndef ETH_DEFS_SVH
`define ETH_DEFS_SVH

// Packet FIFO sizing
`define ETH_FIFO_AW 9                // 512 entries per FIFO

// Ethernet framing constants
`define ETH_PREAMBLE_LEN 7           // Preamble bytes ahead of the SFD
`define ETH_PREAMBLE_BYTE 8'h55      // Alternating 1/0 pattern
`define ETH_SFD 8'hD5                // Start-of-frame delimiter

// Minimum idle time between frames, in byte times
`define ETH_IPG_LEN 12

`endif

//--- common/eth_pkg.sv
`include "eth_defs.svh"

package eth_pkg;

    typedef logic [7:0] eth_byte_t;                   // One octet on the wire
    typedef logic [8:0] fifo_word_t;                  // {byte, last} as stored in FIFO
    typedef logic [`ETH_FIFO_AW-1:0] fifo_ptr_t;      // FIFO memory address

    // Transmit framer states
    typedef enum logic [2:0] {
        TX_IDLE,                                      // Waiting for a committed packet
        TX_PREAMBLE,                                  // Sending 55 bytes
        TX_SFD,                                       // Sending D5
        TX_DATA,                                      // Streaming payload from FIFO
        TX_GAP                                        // Inter-packet gap
    } tx_state_t;

    // Receive deframer states
    typedef enum logic [1:0] {
        RX_IDLE,                                      // Line quiet
        RX_PREAMBLE,                                  // Hunting for SFD
        RX_DATA,                                      // Payload into FIFO
        RX_DISCARD                                    // Bad frame, wait for dv low
    } rx_state_t;

endpackage

//--- verilog/pkt_fifo.sv
`timescale 1ns/1ps
`include "eth_defs.svh"

module pkt_fifo #(
    parameter int AW = `ETH_FIFO_AW                  // Depth is 2**AW
) (
    input  logic               clk_125,
    input  logic               i_reset_n,
    // Write side
    input  logic               i_wr_valid,
    input  eth_pkg::eth_byte_t i_wr_data,
    input  logic               i_wr_last,            // Commits the pending frame
    input  logic               i_wr_drop,            // Discards the pending frame
    output logic               o_wr_ready,
    // Read side, committed bytes only
    output logic               o_rd_valid,
    output eth_pkg::eth_byte_t o_rd_data,
    output logic               o_rd_last,
    input  logic               i_rd_ready
);

    localparam int DEPTH = 1 << AW;

    eth_pkg::fifo_word_t mem [DEPTH];                // No reset on storage

    // Pointers carry one extra wrap bit
    logic [AW:0] rd_ptr;                             // Next word to read
    logic [AW:0] commit_ptr;                         // End of last committed frame
    logic [AW:0] pend_ptr;                           // Next free slot, pending frame
    logic [AW:0] used;                               // Words held, pending included
    logic [AW:0] pkt_cnt;                            // Committed packets not yet read

    logic        full;
    logic        do_write;
    logic        do_drop;
    logic        do_commit;
    logic        do_read;
    logic        do_rd_last;
    eth_pkg::fifo_word_t rd_word;

    assign used = pend_ptr - rd_ptr;
    assign full = used[AW];                          // Exactly DEPTH words held

    assign do_drop    = i_wr_valid && i_wr_drop;     // Drop ignores ready
    assign do_write   = i_wr_valid && !i_wr_drop && !full;
    assign do_commit  = do_write && i_wr_last;
    assign do_read    = o_rd_valid && i_rd_ready;
    assign do_rd_last = do_read && o_rd_last;

    assign o_wr_ready = !full;
    assign o_rd_valid = (pkt_cnt != '0);

    // Read straight out of the array, no latency
    assign rd_word   = mem[rd_ptr[AW-1:0]];
    assign o_rd_data = rd_word[8:1];
    assign o_rd_last = rd_word[0];

    always_ff @(posedge clk_125) begin
        if (do_write) begin
            mem[pend_ptr[AW-1:0]] <= {i_wr_data, i_wr_last};
        end
    end

    // Write pointers
    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            pend_ptr   <= '0;
            commit_ptr <= '0;
        end else if (do_drop) begin
            pend_ptr <= commit_ptr;                  // Rewind to last good frame
        end else if (do_write) begin
            pend_ptr <= pend_ptr + 1'b1;
            if (i_wr_last) begin
                commit_ptr <= pend_ptr + 1'b1;       // Frame now visible to reader
            end
        end
    end

    // Read pointer
    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            rd_ptr <= '0;
        end else if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Packet count, commit and last-byte read cancel out
    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            pkt_cnt <= '0;
        end else begin
            case ({do_commit, do_rd_last})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

    // Occupancy never passes the depth, so no write landed on a full FIFO
    a_no_overflow: assert property (
        @(posedge clk_125) disable iff (!i_reset_n)
        used[AW] |-> (used[AW-1:0] == '0)
    ) else $error("pkt_fifo: write while full");

    // Reader never runs ahead of the committed data
    a_cnt_tracks_ptrs: assert property (
        @(posedge clk_125) disable iff (!i_reset_n)
        (pkt_cnt == '0) == (rd_ptr == commit_ptr)
    ) else $error("pkt_fifo: read with no committed packet");

endmodule

//--- mac/gmii_tx_framer.sv
`timescale 1ns/1ps
`include "eth_defs.svh"

module gmii_tx_framer (
    input  logic               clk_125,
    input  logic               i_reset_n,
    // Committed packet stream from TX FIFO
    input  logic               i_valid,
    input  eth_pkg::eth_byte_t i_data,
    input  logic               i_last,
    output logic               o_ready,
    // GMII transmit
    output eth_pkg::eth_byte_t o_gmii_txd,
    output logic               o_gmii_tx_en
);

    eth_pkg::tx_state_t state;
    logic [3:0]         cnt;                         // Preamble and gap counter

    // Pull one byte per cycle while in DATA
    assign o_ready = (state == eth_pkg::TX_DATA);

    // Byte lane, registered toward the PHY
    always_ff @(posedge clk_125) begin
        case (state)
            eth_pkg::TX_PREAMBLE: o_gmii_txd <= `ETH_PREAMBLE_BYTE;
            eth_pkg::TX_SFD:      o_gmii_txd <= `ETH_SFD;
            eth_pkg::TX_DATA:     o_gmii_txd <= i_data;
            default:              o_gmii_txd <= o_gmii_txd;  // Don't care with tx_en low
        endcase
    end

    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            state        <= eth_pkg::TX_IDLE;
            cnt          <= '0;
            o_gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                eth_pkg::TX_IDLE: begin
                    o_gmii_tx_en <= 1'b0;
                    cnt          <= '0;
                    if (i_valid) begin               // Whole packet already stored
                        state <= eth_pkg::TX_PREAMBLE;
                    end
                end
                eth_pkg::TX_PREAMBLE: begin
                    o_gmii_tx_en <= 1'b1;
                    if (cnt == 4'(`ETH_PREAMBLE_LEN - 1)) begin
                        state <= eth_pkg::TX_SFD;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                eth_pkg::TX_SFD: begin
                    o_gmii_tx_en <= 1'b1;
                    state        <= eth_pkg::TX_DATA;
                end
                eth_pkg::TX_DATA: begin
                    o_gmii_tx_en <= 1'b1;
                    if (i_last) begin                // Final payload byte taken
                        state <= eth_pkg::TX_GAP;
                        cnt   <= '0;
                    end
                end
                eth_pkg::TX_GAP: begin
                    o_gmii_tx_en <= 1'b0;
                    if (cnt == 4'(`ETH_IPG_LEN - 1)) begin
                        state <= eth_pkg::TX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state        <= eth_pkg::TX_IDLE;
                    o_gmii_tx_en <= 1'b0;
                end
            endcase
        end
    end

    // Store-and-forward upstream means the FIFO never runs dry mid-frame
    a_no_underrun: assert property (
        @(posedge clk_125) disable iff (!i_reset_n)
        (state == eth_pkg::TX_DATA) |-> i_valid
    ) else $error("gmii_tx_framer: FIFO empty during DATA");

    // Line stays quiet for the full gap after each frame
    a_ipg: assert property (
        @(posedge clk_125) disable iff (!i_reset_n)
        $fell(o_gmii_tx_en) |-> !o_gmii_tx_en [*`ETH_IPG_LEN]
    ) else $error("gmii_tx_framer: inter-packet gap too short");

endmodule

//--- mac/gmii_rx_deframer.sv
`timescale 1ns/1ps
`include "eth_defs.svh"

module gmii_rx_deframer (
    input  logic               clk_125,
    input  logic               i_reset_n,
    // GMII receive
    input  eth_pkg::eth_byte_t i_gmii_rxd,
    input  logic               i_gmii_rx_dv,
    input  logic               i_gmii_rx_er,
    // Write side of RX FIFO
    input  logic               i_ready,
    output logic               o_valid,
    output eth_pkg::eth_byte_t o_data,
    output logic               o_last,
    output logic               o_drop
);

    eth_pkg::rx_state_t state;
    eth_pkg::eth_byte_t hold_data;                   // One byte behind the wire
    logic               hold_valid;
    logic               wrote;                       // FIFO holds bytes of this frame
    logic               data_bad;
    logic               emit;

    // Error on the line, or held byte has nowhere to go
    assign data_bad = (state == eth_pkg::RX_DATA)
                    && (i_gmii_rx_er || (hold_valid && !i_ready));
    assign emit     = (state == eth_pkg::RX_DATA) && hold_valid && !data_bad;

    assign o_data  = hold_data;
    assign o_last  = emit && !i_gmii_rx_dv;          // dv fell, held byte ends frame
    assign o_drop  = (state == eth_pkg::RX_DISCARD) && wrote;
    assign o_valid = emit || o_drop;

    always_ff @(posedge clk_125) begin
        if (state == eth_pkg::RX_DATA && i_gmii_rx_dv) begin
            hold_data <= i_gmii_rxd;
        end
    end

    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            state      <= eth_pkg::RX_IDLE;
            hold_valid <= 1'b0;
            wrote      <= 1'b0;
        end else begin
            case (state)
                eth_pkg::RX_IDLE: begin
                    if (i_gmii_rx_dv) begin
                        if (i_gmii_rx_er)
                            state <= eth_pkg::RX_DISCARD;
                        else if (i_gmii_rxd == `ETH_SFD)
                            state <= eth_pkg::RX_DATA;   // Preamble was cut short
                        else
                            state <= eth_pkg::RX_PREAMBLE;
                    end
                end
                eth_pkg::RX_PREAMBLE: begin
                    if (!i_gmii_rx_dv || i_gmii_rx_er)
                        state <= eth_pkg::RX_DISCARD;
                    else if (i_gmii_rxd == `ETH_SFD)
                        state <= eth_pkg::RX_DATA;
                    else if (i_gmii_rxd != `ETH_PREAMBLE_BYTE)
                        state <= eth_pkg::RX_DISCARD;
                end
                eth_pkg::RX_DATA: begin
                    if (data_bad) begin
                        state      <= eth_pkg::RX_DISCARD;
                        hold_valid <= 1'b0;
                    end else if (!i_gmii_rx_dv) begin
                        state      <= eth_pkg::RX_IDLE;  // Last byte written now
                        hold_valid <= 1'b0;
                        wrote      <= 1'b0;
                    end else begin
                        hold_valid <= 1'b1;
                        if (emit) wrote <= 1'b1;
                    end
                end
                eth_pkg::RX_DISCARD: begin
                    wrote <= 1'b0;                   // Drop strobe goes out once
                    if (!i_gmii_rx_dv) state <= eth_pkg::RX_IDLE;
                end
                default: state <= eth_pkg::RX_IDLE;
            endcase
        end
    end

    // Byte written with last is the final one seen before dv fell
    a_last_byte: assert property (
        @(posedge clk_125) disable iff (!i_reset_n)
        (o_valid && o_last) |-> ($past(i_gmii_rx_dv) && (o_data == $past(i_gmii_rxd)))
    ) else $error("gmii_rx_deframer: last byte is not the final byte on the wire");

endmodule

//--- verilog/eth_mac_fifo.sv
`timescale 1ns/1ps

module eth_mac_fifo (
    input  logic               clk_125,
    input  logic               i_reset_n,
    // Host transmit stream
    input  eth_pkg::eth_byte_t i_tx_data,
    input  logic               i_tx_valid,
    input  logic               i_tx_last,
    output logic               o_tx_ready,
    // Host receive stream
    output eth_pkg::eth_byte_t o_rx_data,
    output logic               o_rx_valid,
    output logic               o_rx_last,
    input  logic               i_rx_ready,
    // GMII
    output eth_pkg::eth_byte_t o_gmii_txd,
    output logic               o_gmii_tx_en,
    input  eth_pkg::eth_byte_t i_gmii_rxd,
    input  logic               i_gmii_rx_dv,
    input  logic               i_gmii_rx_er
);

    localparam int FIFO_AW = $bits(eth_pkg::fifo_ptr_t);

    // TX FIFO to framer
    logic               txf_valid;
    eth_pkg::eth_byte_t txf_data;
    logic               txf_last;
    logic               txf_ready;

    // Deframer to RX FIFO
    logic               rxf_valid;
    eth_pkg::eth_byte_t rxf_data;
    logic               rxf_last;
    logic               rxf_drop;
    logic               rxf_ready;

    pkt_fifo #(.AW(FIFO_AW)) u_tx_fifo (
        .clk_125    (clk_125),
        .i_reset_n  (i_reset_n),
        .i_wr_valid (i_tx_valid),
        .i_wr_data  (i_tx_data),
        .i_wr_last  (i_tx_last),
        .i_wr_drop  (1'b0),                          // Host frames are never aborted
        .o_wr_ready (o_tx_ready),
        .o_rd_valid (txf_valid),
        .o_rd_data  (txf_data),
        .o_rd_last  (txf_last),
        .i_rd_ready (txf_ready)
    );

    gmii_tx_framer u_tx_framer (
        .clk_125      (clk_125),
        .i_reset_n    (i_reset_n),
        .i_valid      (txf_valid),
        .i_data       (txf_data),
        .i_last       (txf_last),
        .o_ready      (txf_ready),
        .o_gmii_txd   (o_gmii_txd),
        .o_gmii_tx_en (o_gmii_tx_en)
    );

    gmii_rx_deframer u_rx_deframer (
        .clk_125      (clk_125),
        .i_reset_n    (i_reset_n),
        .i_gmii_rxd   (i_gmii_rxd),
        .i_gmii_rx_dv (i_gmii_rx_dv),
        .i_gmii_rx_er (i_gmii_rx_er),
        .i_ready      (rxf_ready),
        .o_valid      (rxf_valid),
        .o_data       (rxf_data),
        .o_last       (rxf_last),
        .o_drop       (rxf_drop)
    );

    pkt_fifo #(.AW(FIFO_AW)) u_rx_fifo (
        .clk_125    (clk_125),
        .i_reset_n  (i_reset_n),
        .i_wr_valid (rxf_valid),
        .i_wr_data  (rxf_data),
        .i_wr_last  (rxf_last),
        .i_wr_drop  (rxf_drop),                      // Bad frames rolled back here
        .o_wr_ready (rxf_ready),
        .o_rd_valid (o_rx_valid),
        .o_rd_data  (o_rx_data),
        .o_rd_last  (o_rx_last),
        .i_rd_ready (i_rx_ready)
    );

endmodule

//--- test/tb_eth_mac_fifo.sv
`timescale 1ns/1ps
`include "eth_defs.svh"

module tb_eth_mac_fifo;

    localparam int SEED           = 20790;
    localparam int MAX_LEN        = 64;              // Longest random payload
    localparam int TX_PKTS        = 20;
    localparam int RX_GOOD        = 20;
    localparam int RX_BAD         = RX_GOOD / 2;     // One after every second good frame
    localparam int OVF_FRAMES     = 10;
    localparam int OVF_LEN        = 64;
    localparam int BP_PKTS        = 640;             // Tiny packets, framer overhead dominates
    localparam int FIFO_DEPTH     = 1 << `ETH_FIFO_AW;
    localparam int STIM_BYTES     = (TX_PKTS + RX_GOOD + RX_BAD) * MAX_LEN
                                  + OVF_FRAMES * OVF_LEN + BP_PKTS * 2;
    localparam int TIMEOUT_CYCLES = 40 * STIM_BYTES + 2000;

    logic               clk_125      = 1'b0;
    logic               i_reset_n    = 1'b0;
    eth_pkg::eth_byte_t i_tx_data    = '0;
    logic               i_tx_valid   = 1'b0;
    logic               i_tx_last    = 1'b0;
    logic               o_tx_ready;
    eth_pkg::eth_byte_t o_rx_data;
    logic               o_rx_valid;
    logic               o_rx_last;
    logic               i_rx_ready   = 1'b0;
    eth_pkg::eth_byte_t o_gmii_txd;
    logic               o_gmii_tx_en;
    eth_pkg::eth_byte_t i_gmii_rxd   = '0;
    logic               i_gmii_rx_dv = 1'b0;
    logic               i_gmii_rx_er = 1'b0;

    // Host transmit bytes still to offer, and payload expected on GMII
    eth_pkg::eth_byte_t tx_send_data [$];
    logic               tx_send_last [$];
    eth_pkg::eth_byte_t tx_exp_data  [$];
    logic               tx_exp_last  [$];
    // Good receive frames not yet read by the host
    eth_pkg::eth_byte_t rx_exp_data  [$];
    logic               rx_exp_last  [$];

    logic tx_gaps          = 1'b0;                   // Random idle cycles on host valid
    logic tx_accept        = 1'b0;                   // Offered byte taken at next posedge
    logic saw_tx_stall     = 1'b0;
    logic rx_drain         = 1'b0;                   // Host reads, ready random
    logic tx_in_frame      = 1'b0;
    logic tx_prev_last     = 1'b0;                   // Last payload byte matched packet end
    int   tx_frames_sent   = 0;
    int   tx_frames_seen   = 0;
    int   tx_last_accepted = 0;                      // Packets fully written by host
    int   tx_pos           = 0;                      // Byte index inside tx_en burst
    int   tx_gap_cnt       = 0;
    int   cycle_cnt        = 0;

    eth_mac_fifo u_dut (
        .clk_125      (clk_125),
        .i_reset_n    (i_reset_n),
        .i_tx_data    (i_tx_data),
        .i_tx_valid   (i_tx_valid),
        .i_tx_last    (i_tx_last),
        .o_tx_ready   (o_tx_ready),
        .o_rx_data    (o_rx_data),
        .o_rx_valid   (o_rx_valid),
        .o_rx_last    (o_rx_last),
        .i_rx_ready   (i_rx_ready),
        .o_gmii_txd   (o_gmii_txd),
        .o_gmii_tx_en (o_gmii_tx_en),
        .i_gmii_rxd   (i_gmii_rxd),
        .i_gmii_rx_dv (i_gmii_rx_dv),
        .i_gmii_rx_er (i_gmii_rx_er)
    );

    always #2 clk_125 = ~clk_125;                    // 250 MHz sim clock, 4 ns period

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_with($sformatf("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                                $time, name, expected, actual));
        end
    endtask

    // Random payload into both the host queue and the GMII expectation
    task automatic queue_tx_packet(input int len);
        int                 i;
        eth_pkg::eth_byte_t b;
        for (i = 0; i < len; i++) begin
            b = 8'($urandom);
            tx_send_data.push_back(b);
            tx_send_last.push_back(i == len - 1);
            tx_exp_data.push_back(b);
            tx_exp_last.push_back(i == len - 1);
        end
        tx_frames_sent++;
    endtask

    // Preamble, SFD, payload, then idle gap; err_at < 0 means a clean frame
    task automatic send_gmii_frame(input int len, input int err_at, input logic keep);
        int                 i;
        eth_pkg::eth_byte_t b;
        for (i = 0; i < `ETH_PREAMBLE_LEN; i++) begin
            @(negedge clk_125);
            i_gmii_rx_dv = 1'b1;
            i_gmii_rxd   = `ETH_PREAMBLE_BYTE;
        end
        @(negedge clk_125);
        i_gmii_rxd = `ETH_SFD;
        for (i = 0; i < len; i++) begin
            b = 8'($urandom);
            if (keep) begin                          // Only surviving frames reach host
                rx_exp_data.push_back(b);
                rx_exp_last.push_back(i == len - 1);
            end
            @(negedge clk_125);
            i_gmii_rxd   = b;
            i_gmii_rx_er = (i == err_at);
        end
        @(negedge clk_125);
        i_gmii_rx_dv = 1'b0;
        i_gmii_rx_er = 1'b0;
        i_gmii_rxd   = '0;
        repeat (`ETH_IPG_LEN) @(negedge clk_125);
    endtask

    task automatic wait_tx_frames();
        while (tx_frames_seen < tx_frames_sent) @(negedge clk_125);
    endtask

    task automatic wait_rx_drained();
        while (rx_exp_data.size() != 0) @(negedge clk_125);
        repeat (2 * `ETH_IPG_LEN) @(negedge clk_125);
        check_value("o_rx_valid", o_rx_valid, 0);    // Dropped frames left nothing behind
    endtask

    // Host transmit driver, valid held until the byte is taken
    always @(negedge clk_125) begin
        if (tx_accept) begin
            if (tx_send_last[0]) tx_last_accepted++;
            void'(tx_send_data.pop_front());
            void'(tx_send_last.pop_front());
        end
        if (o_tx_ready === 1'b0) saw_tx_stall = 1'b1;
        if (i_tx_valid && !tx_accept) begin
            i_tx_valid = 1'b1;                       // Same byte stays on offer
        end else if (tx_send_data.size() != 0 && !(tx_gaps && ($urandom % 4) == 0)) begin
            i_tx_valid = 1'b1;
            i_tx_data  = tx_send_data[0];
            i_tx_last  = tx_send_last[0];
        end else begin
            i_tx_valid = 1'b0;
        end
        tx_accept = i_tx_valid && (o_tx_ready === 1'b1);  // Ready is registered
    end

    // GMII transmit monitor
    always @(negedge clk_125) begin
        if (o_gmii_tx_en === 1'b1) begin
            if (!tx_in_frame) begin
                if (tx_frames_seen >= tx_last_accepted)
                    fail_with("o_gmii_tx_en rose before its packet was fully accepted");
                else if (tx_frames_seen > 0 && tx_gap_cnt < `ETH_IPG_LEN)
                    fail_with($sformatf("Gap of %0d idle cycles between frames, need %0d",
                                        tx_gap_cnt, `ETH_IPG_LEN));
                tx_in_frame  = 1'b1;
                tx_pos       = 0;
                tx_prev_last = 1'b0;
            end
            if (tx_pos < `ETH_PREAMBLE_LEN) begin
                check_value("o_gmii_txd", o_gmii_txd, `ETH_PREAMBLE_BYTE);
            end else if (tx_pos == `ETH_PREAMBLE_LEN) begin
                check_value("o_gmii_txd", o_gmii_txd, `ETH_SFD);
            end else if (tx_prev_last || tx_exp_data.size() == 0) begin
                fail_with("Frame on GMII runs past the end of its packet");
            end else begin
                tx_prev_last = tx_exp_last.pop_front();
                check_value("o_gmii_txd", o_gmii_txd, tx_exp_data.pop_front());
            end
            tx_pos++;
        end else begin
            if (tx_in_frame) begin
                if (!tx_prev_last)
                    fail_with("o_gmii_tx_en fell before the end of the packet");
                tx_in_frame = 1'b0;
                tx_frames_seen++;
                tx_gap_cnt = 0;
            end
            tx_gap_cnt++;
        end
    end

    // Host receive side, ready and the byte check decided together
    always @(negedge clk_125) begin
        i_rx_ready = rx_drain && (($urandom % 4) != 0);
        if (o_rx_valid === 1'b1 && i_rx_ready) begin
            if (rx_exp_data.size() == 0) begin
                fail_with("Host receive stream delivered a byte of no good frame");
            end else begin
                check_value("o_rx_data", o_rx_data, rx_exp_data.pop_front());
                check_value("o_rx_last", o_rx_last, rx_exp_last.pop_front());
            end
        end
    end

    always @(posedge clk_125) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES)
            fail_with($sformatf("Timeout after %0d cycles, test did not finish", cycle_cnt));
    end

    initial begin
        int   k;
        int   len;
        int   stored;
        logic keep;
        void'($urandom(SEED));
        repeat (3) @(negedge clk_125);
        i_reset_n = 1'b1;
        @(negedge clk_125);
        check_value("o_tx_ready", o_tx_ready, 1);
        check_value("o_rx_valid", o_rx_valid, 0);
        check_value("o_gmii_tx_en", o_gmii_tx_en, 0);

        // Transmit framing, store-and-forward and gap
        tx_gaps = 1'b1;
        for (k = 0; k < TX_PKTS; k++) queue_tx_packet(1 + $urandom % MAX_LEN);
        wait_tx_frames();

        // Receive path, errored frames interleaved
        rx_drain = 1'b1;
        for (k = 0; k < RX_GOOD; k++) begin
            send_gmii_frame(1 + $urandom % MAX_LEN, -1, 1'b1);
            if (k % 2 == 1) begin
                len = 1 + $urandom % MAX_LEN;
                send_gmii_frame(len, $urandom % len, 1'b0);
            end
        end
        wait_rx_drained();

        // Overflow with the host stalled
        rx_drain = 1'b0;
        stored   = 0;
        for (k = 0; k < OVF_FRAMES; k++) begin
            keep = (stored + OVF_LEN <= FIFO_DEPTH);
            if (keep) stored += OVF_LEN;
            send_gmii_frame(OVF_LEN, -1, keep);
        end
        rx_drain = 1'b1;
        wait_rx_drained();

        // Transmit back-pressure, host valid never idles
        tx_gaps      = 1'b0;
        saw_tx_stall = 1'b0;
        for (k = 0; k < BP_PKTS; k++) queue_tx_packet(1 + $urandom % 2);
        wait_tx_frames();
        if (!saw_tx_stall) begin
            fail_with("o_tx_ready never went low while the transmit FIFO was over-filled");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- compile.f
+incdir+common
common/eth_pkg.sv
verilog/pkt_fifo.sv
mac/gmii_tx_framer.sv
mac/gmii_rx_deframer.sv
verilog/eth_mac_fifo.sv
test/tb_eth_mac_fifo.sv

//--- Makefile
# Verilator flow for the Ethernet MAC packet FIFO

VERILATOR  ?= verilator
TOP        ?= tb_eth_mac_fifo
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAIL" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
